//--- Bender.yml
package:
  name: id_stage

sources:
  - common/id_pkg.sv
  - decode/inst_decoder.sv
  - src/regfile.sv
  - src/forward_unit.sv
  - src/branch_unit.sv
  - src/id_control.sv
  - src/id_stage.sv
  - target: simulation
    files:
      - test/tb_id_stage.sv

//--- common/id_pkg.sv
package id_pkg;

  localparam int xlen       = 32;
  localparam int reg_addr_w = 5;
  localparam int num_regs   = 32;

  // decoded instruction, one member per supported opcode
  typedef enum logic [5:0] {
    op_invalid,
    op_add, op_sub, op_slt, op_sltu, op_nor, op_and,
    op_or, op_xor, op_sll, op_srl, op_sra,
    op_slli, op_srli, op_srai, op_slti, op_sltui,
    op_addi, op_andi, op_ori, op_xori,
    op_lu12i, op_pcaddu12i,
    op_ld_b, op_ld_h, op_ld_w, op_ld_bu, op_ld_hu,
    op_st_b, op_st_h, op_st_w,
    op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu,
    op_b, op_bl, op_jirl
  } op_t;

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_slt, alu_sltu,
    alu_and, alu_nor, alu_or, alu_xor,
    alu_sll, alu_srl, alu_sra, alu_lui
  } alu_op_t;

  typedef enum logic [1:0] {
    mem_none, mem_byte, mem_half, mem_word
  } mem_width_t;

  typedef struct packed {
    logic [xlen-1:0] pc;
    logic [xlen-1:0] inst;
  } if_to_id_t;

  // write intent of a later stage
  typedef struct packed {
    logic                  valid;
    logic                  reg_write;
    logic                  from_mem;
    logic [reg_addr_w-1:0] addr;
    logic [xlen-1:0]       data;
  } bypass_t;

  typedef struct packed {
    op_t                   op;
    alu_op_t               alu_op;
    logic [reg_addr_w-1:0] rj;
    logic [reg_addr_w-1:0] rkd;
    logic [reg_addr_w-1:0] dest;
    logic                  need_rj;
    logic                  need_rkd;
    logic                  src1_is_pc;
    logic                  src2_is_imm;
    logic                  reg_write;
    logic                  mem_write;
    logic                  load_sign;
    mem_width_t            mem_width;
    logic [xlen-1:0]       imm;
    // raw branch offset, offs26 with offs16 in the low bits
    logic [25:0]           offs;
  } decode_t;

  typedef struct packed {
    logic            stall;
    logic            taken;
    logic [xlen-1:0] target;
  } br_to_if_t;

  typedef struct packed {
    alu_op_t               alu_op;
    logic                  res_from_mem;
    logic                  reg_write;
    logic                  mem_write;
    logic [reg_addr_w-1:0] dest;
    logic [xlen-1:0]       store_data;
    logic [xlen-1:0]       src1;
    logic [xlen-1:0]       src2;
    mem_width_t            mem_width;
    logic                  load_sign;
    logic [xlen-1:0]       pc;
  } id_to_exe_t;

endpackage

//--- decode/inst_decoder.sv
`timescale 1ns/1ps

module inst_decoder (
  input  logic [id_pkg::xlen-1:0] inst,
  output id_pkg::decode_t         dec
);
  import id_pkg::*;

  logic [reg_addr_w-1:0] rd;
  logic [reg_addr_w-1:0] rj;
  logic [reg_addr_w-1:0] rk;
  logic [11:0]           i12;
  logic [19:0]           i20;
  logic [xlen-1:0]       imm;
  op_t                   op;
  logic                  reg_alu;
  logic                  cond_br;
  logic                  is_store;

  assign rd  = inst[4:0];
  assign rj  = inst[9:5];
  assign rk  = inst[14:10];
  assign i12 = inst[21:10];
  assign i20 = inst[24:5];

  // fields 31:26, 25:22, 21:20, 19:15
  always_comb begin
    casez (inst[31:15])
      17'b000000_0000_01_00000: op = op_add;
      17'b000000_0000_01_00010: op = op_sub;
      17'b000000_0000_01_00100: op = op_slt;
      17'b000000_0000_01_00101: op = op_sltu;
      17'b000000_0000_01_01000: op = op_nor;
      17'b000000_0000_01_01001: op = op_and;
      17'b000000_0000_01_01010: op = op_or;
      17'b000000_0000_01_01011: op = op_xor;
      17'b000000_0000_01_01110: op = op_sll;
      17'b000000_0000_01_01111: op = op_srl;
      17'b000000_0000_01_10000: op = op_sra;
      17'b000000_0001_00_00001: op = op_slli;
      17'b000000_0001_00_01001: op = op_srli;
      17'b000000_0001_00_10001: op = op_srai;
      17'b000000_1000_??_?????: op = op_slti;
      17'b000000_1001_??_?????: op = op_sltui;
      17'b000000_1010_??_?????: op = op_addi;
      17'b000000_1101_??_?????: op = op_andi;
      17'b000000_1110_??_?????: op = op_ori;
      17'b000000_1111_??_?????: op = op_xori;
      17'b000101_0???_??_?????: op = op_lu12i;
      17'b000111_0???_??_?????: op = op_pcaddu12i;
      17'b001010_0000_??_?????: op = op_ld_b;
      17'b001010_0001_??_?????: op = op_ld_h;
      17'b001010_0010_??_?????: op = op_ld_w;
      17'b001010_0100_??_?????: op = op_st_b;
      17'b001010_0101_??_?????: op = op_st_h;
      17'b001010_0110_??_?????: op = op_st_w;
      17'b001010_1000_??_?????: op = op_ld_bu;
      17'b001010_1001_??_?????: op = op_ld_hu;
      17'b010011_????_??_?????: op = op_jirl;
      17'b010100_????_??_?????: op = op_b;
      17'b010101_????_??_?????: op = op_bl;
      17'b010110_????_??_?????: op = op_beq;
      17'b010111_????_??_?????: op = op_bne;
      17'b011000_????_??_?????: op = op_blt;
      17'b011001_????_??_?????: op = op_bge;
      17'b011010_????_??_?????: op = op_bltu;
      17'b011011_????_??_?????: op = op_bgeu;
      default:                  op = op_invalid;
    endcase
  end

  assign reg_alu  = op inside {op_add, op_sub, op_slt, op_sltu, op_nor, op_and,
                               op_or, op_xor, op_sll, op_srl, op_sra};
  assign cond_br  = op inside {op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu};
  assign is_store = op inside {op_st_b, op_st_h, op_st_w};

  // link value 4, upper immediate, ui12, ui5, else si12
  assign imm = (op inside {op_jirl, op_bl})           ? xlen'(4) :
               (op inside {op_lu12i, op_pcaddu12i})   ? {i20, 12'b0} :
               (op inside {op_andi, op_ori, op_xori}) ? {20'b0, i12} :
               (op inside {op_slli, op_srli, op_srai}) ? {27'b0, rk} :
               {{20{i12[11]}}, i12};

  always_comb begin
    dec             = '0;
    dec.op          = op;
    dec.rj          = rj;
    dec.rkd         = (is_store || cond_br) ? rd : rk;
    dec.dest        = (op == op_bl) ? reg_addr_w'(1) : rd;
    dec.need_rj     = (op != op_invalid) && !(op inside {op_b, op_bl, op_lu12i, op_pcaddu12i});
    dec.need_rkd    = reg_alu || is_store || cond_br;
    dec.src1_is_pc  = op inside {op_jirl, op_bl, op_pcaddu12i};
    dec.src2_is_imm = !(reg_alu || cond_br || op inside {op_b, op_invalid});
    dec.reg_write   = (op != op_invalid) && !is_store && !cond_br && (op != op_b);
    dec.mem_write   = is_store;
    dec.load_sign   = op inside {op_ld_b, op_ld_h, op_ld_w};
    dec.imm         = imm;
    dec.offs        = {inst[9:0], inst[25:10]};
    case (op)
      op_ld_b, op_ld_bu, op_st_b: dec.mem_width = mem_byte;
      op_ld_h, op_ld_hu, op_st_h: dec.mem_width = mem_half;
      op_ld_w, op_st_w:           dec.mem_width = mem_word;
      default:                    dec.mem_width = mem_none;
    endcase
    case (op)
      op_sub:             dec.alu_op = alu_sub;
      op_slt, op_slti:    dec.alu_op = alu_slt;
      op_sltu, op_sltui:  dec.alu_op = alu_sltu;
      op_and, op_andi:    dec.alu_op = alu_and;
      op_nor:             dec.alu_op = alu_nor;
      op_or, op_ori:      dec.alu_op = alu_or;
      op_xor, op_xori:    dec.alu_op = alu_xor;
      op_sll, op_slli:    dec.alu_op = alu_sll;
      op_srl, op_srli:    dec.alu_op = alu_srl;
      op_sra, op_srai:    dec.alu_op = alu_sra;
      op_lu12i:           dec.alu_op = alu_lui;
      default:            dec.alu_op = alu_add;
    endcase
  end

endmodule

//--- sim.f
common/id_pkg.sv
decode/inst_decoder.sv
src/regfile.sv
src/forward_unit.sv
src/branch_unit.sv
src/id_control.sv
src/id_stage.sv
test/tb_id_stage.sv

//--- src/branch_unit.sv
`timescale 1ns/1ps

module branch_unit (
  input  logic                    valid,
  input  id_pkg::decode_t         dec,
  input  logic [id_pkg::xlen-1:0] pc,
  input  logic [id_pkg::xlen-1:0] fwd_rj,
  input  logic [id_pkg::xlen-1:0] fwd_rkd,
  input  logic                    hazard,
  output id_pkg::br_to_if_t       br,
  output logic                    taken
);
  import id_pkg::*;

  logic            eq;
  logic            lt_s;
  logic            lt_u;
  logic            cond;
  logic [xlen-1:0] offset;
  logic [xlen-1:0] base;

  assign eq   = (fwd_rj == fwd_rkd);
  assign lt_s = $signed(fwd_rj) < $signed(fwd_rkd);
  assign lt_u = fwd_rj < fwd_rkd;

  always_comb begin
    case (dec.op)
      op_beq:                 cond = eq;
      op_bne:                 cond = ~eq;
      op_blt:                 cond = lt_s;
      op_bge:                 cond = ~lt_s;
      op_bltu:                cond = lt_u;
      op_bgeu:                cond = ~lt_u;
      op_b, op_bl, op_jirl:   cond = 1'b1;
      default:                cond = 1'b0;
    endcase
  end

  assign taken = valid & cond;

  // offs26 for b and bl, offs16 for the rest
  assign offset = (dec.op inside {op_b, op_bl}) ? {{4{dec.offs[25]}}, dec.offs, 2'b0} :
                  {{14{dec.offs[15]}}, dec.offs[15:0], 2'b0};
  assign base   = (dec.op == op_jirl) ? fwd_rj : pc;

  assign br.stall  = taken & hazard;
  assign br.taken  = taken;
  assign br.target = base + offset;

endmodule

//--- src/forward_unit.sv
`timescale 1ns/1ps

module forward_unit (
  input  logic                    valid,
  input  id_pkg::decode_t         dec,
  input  logic [id_pkg::xlen-1:0] rdata1,
  input  logic [id_pkg::xlen-1:0] rdata2,
  input  id_pkg::bypass_t         exe_bypass,
  input  id_pkg::bypass_t         mem_bypass,
  input  id_pkg::bypass_t         wb_bypass,
  output logic [id_pkg::xlen-1:0] fwd_rj,
  output logic [id_pkg::xlen-1:0] fwd_rkd,
  output logic                    hazard
);
  import id_pkg::*;

  logic use_rj;
  logic use_rkd;

  function automatic logic hits(input bypass_t b, input logic [reg_addr_w-1:0] addr);
    return b.valid && b.reg_write && (b.addr == addr);
  endfunction

  // youngest writer wins: exe, then mem, then wb
  function automatic logic [xlen-1:0] pick(
    input logic                  use_fwd,
    input logic [reg_addr_w-1:0] addr,
    input logic [xlen-1:0]       rf_data,
    input bypass_t               e,
    input bypass_t               m,
    input bypass_t               w
  );
    logic [xlen-1:0] data;
    data = rf_data;
    if (use_fwd) begin
      if (hits(e, addr)) begin
        data = e.data;
      end else if (hits(m, addr)) begin
        data = m.data;
      end else if (hits(w, addr)) begin
        data = w.data;
      end
    end
    return data;
  endfunction

  assign use_rj  = valid && dec.need_rj && (dec.rj != '0);
  assign use_rkd = valid && dec.need_rkd && (dec.rkd != '0);

  assign fwd_rj  = pick(use_rj, dec.rj, rdata1, exe_bypass, mem_bypass, wb_bypass);
  assign fwd_rkd = pick(use_rkd, dec.rkd, rdata2, exe_bypass, mem_bypass, wb_bypass);

  // load data is not ready until mem
  assign hazard = exe_bypass.valid && exe_bypass.from_mem &&
                  ((use_rj && exe_bypass.addr == dec.rj) ||
                   (use_rkd && exe_bypass.addr == dec.rkd));

endmodule

//--- src/id_control.sv
`timescale 1ns/1ps

module id_control (
  input  logic              clk,
  input  logic              reset,
  input  logic              if_valid,
  input  id_pkg::if_to_id_t if_bus,
  output logic              id_allowin,
  input  logic              exe_allowin,
  output logic              exe_valid,
  input  logic              hazard,
  input  logic              br_taken,
  output logic              valid,
  output id_pkg::if_to_id_t id_data
);

  logic ready_go;
  logic br_cancel;

  // only a load-use hazard holds the stage
  assign ready_go   = ~hazard;
  assign id_allowin = ~valid | (ready_go & exe_allowin);
  assign exe_valid  = valid & ready_go;

  // drop whatever fetch offers behind a resolved branch
  assign br_cancel = br_taken & ready_go;

  always_ff @(posedge clk) begin
    if (reset) begin
      valid <= 1'b0;
    end else if (id_allowin) begin
      valid <= if_valid & ~br_cancel;
    end
  end

  always_ff @(posedge clk) begin
    if (id_allowin && if_valid && !br_cancel) begin
      id_data <= if_bus;
    end
  end

endmodule

//--- src/id_stage.sv
`timescale 1ns/1ps

module id_stage (
  input  logic               clk,
  input  logic               reset,
  input  logic               if_valid,
  input  id_pkg::if_to_id_t  if_bus,
  output logic               id_allowin,
  input  logic               exe_allowin,
  output logic               exe_valid,
  output id_pkg::id_to_exe_t exe_bus,
  output id_pkg::br_to_if_t  br_bus,
  input  id_pkg::bypass_t    exe_bypass,
  input  id_pkg::bypass_t    mem_bypass,
  input  id_pkg::bypass_t    wb_bypass
);
  import id_pkg::*;

  logic            valid;
  if_to_id_t       id_data;
  decode_t         dec;
  logic [xlen-1:0] rdata1;
  logic [xlen-1:0] rdata2;
  logic [xlen-1:0] fwd_rj;
  logic [xlen-1:0] fwd_rkd;
  logic            hazard;
  logic            br_taken;
  logic            rf_we;

  id_control i_id_control (
    .clk        (clk),
    .reset      (reset),
    .if_valid   (if_valid),
    .if_bus     (if_bus),
    .id_allowin (id_allowin),
    .exe_allowin(exe_allowin),
    .exe_valid  (exe_valid),
    .hazard     (hazard),
    .br_taken   (br_taken),
    .valid      (valid),
    .id_data    (id_data)
  );

  inst_decoder i_inst_decoder (
    .inst(id_data.inst),
    .dec (dec)
  );

  // writeback port of the register file
  assign rf_we = wb_bypass.valid & wb_bypass.reg_write;

  regfile i_regfile (
    .clk   (clk),
    .raddr1(dec.rj),
    .raddr2(dec.rkd),
    .rdata1(rdata1),
    .rdata2(rdata2),
    .we    (rf_we),
    .waddr (wb_bypass.addr),
    .wdata (wb_bypass.data)
  );

  forward_unit i_forward_unit (
    .valid     (valid),
    .dec       (dec),
    .rdata1    (rdata1),
    .rdata2    (rdata2),
    .exe_bypass(exe_bypass),
    .mem_bypass(mem_bypass),
    .wb_bypass (wb_bypass),
    .fwd_rj    (fwd_rj),
    .fwd_rkd   (fwd_rkd),
    .hazard    (hazard)
  );

  branch_unit i_branch_unit (
    .valid  (valid),
    .dec    (dec),
    .pc     (id_data.pc),
    .fwd_rj (fwd_rj),
    .fwd_rkd(fwd_rkd),
    .hazard (hazard),
    .br     (br_bus),
    .taken  (br_taken)
  );

  always_comb begin
    exe_bus.alu_op       = dec.alu_op;
    // loads are the only writers with a memory width
    exe_bus.res_from_mem = dec.reg_write && (dec.mem_width != mem_none);
    exe_bus.reg_write    = dec.reg_write;
    exe_bus.mem_write    = dec.mem_write;
    exe_bus.dest         = dec.dest;
    exe_bus.store_data   = fwd_rkd;
    exe_bus.src1         = dec.src1_is_pc ? id_data.pc : fwd_rj;
    exe_bus.src2         = dec.src2_is_imm ? dec.imm : fwd_rkd;
    exe_bus.mem_width    = dec.mem_width;
    exe_bus.load_sign    = dec.load_sign;
    exe_bus.pc           = id_data.pc;
  end

endmodule

//--- src/regfile.sv
`timescale 1ns/1ps

module regfile (
  input  logic                          clk,
  input  logic [id_pkg::reg_addr_w-1:0] raddr1,
  input  logic [id_pkg::reg_addr_w-1:0] raddr2,
  output logic [id_pkg::xlen-1:0]       rdata1,
  output logic [id_pkg::xlen-1:0]       rdata2,
  input  logic                          we,
  input  logic [id_pkg::reg_addr_w-1:0] waddr,
  input  logic [id_pkg::xlen-1:0]       wdata
);
  import id_pkg::*;

  logic [xlen-1:0] rf [num_regs];

  // r0 is never written
  always_ff @(posedge clk) begin
    if (we && waddr != '0) begin
      rf[waddr] <= wdata;
    end
  end

  assign rdata1 = (raddr1 == '0) ? '0 : rf[raddr1];
  assign rdata2 = (raddr2 == '0) ? '0 : rf[raddr2];

endmodule

//--- test/tb_id_stage.sv
`timescale 1ns/1ps

module tb_id_stage;
  import id_pkg::*;

  typedef enum logic [3:0] {
    f_none, f_3r, f_ui5, f_si12, f_ui12, f_u20, f_pcu,
    f_ld, f_st, f_cbr, f_b, f_bl, f_jirl
  } fmt_t;

  typedef struct packed {
    fmt_t       fmt;
    alu_op_t    alu;
    mem_width_t w;
    logic       sgn;
  } kind_t;

  localparam int max_cycles = 4000;

  logic       clk = 1'b0;
  logic       reset;
  logic       if_valid;
  if_to_id_t  if_bus;
  logic       id_allowin;
  logic       exe_allowin;
  logic       exe_valid;
  id_to_exe_t exe_bus;
  br_to_if_t  br_bus;
  bypass_t    exe_bypass;
  bypass_t    mem_bypass;
  bypass_t    wb_bypass;

  logic [31:0] seed = 32'd27;
  logic [31:0] pc_tag = 32'h1000_0000;
  int          cycles = 0;
  logic [31:0] regs [32];
  int          pending = 0;
  logic        m_valid = 1'b0;
  logic [31:0] m_inst = '0;
  logic [31:0] m_pc = '0;

  // 0-21 alu and immediate ops, 22-29 loads and stores, 30-38 branches
  logic [31:0] ops [39] = '{
    32'h0010_0000, 32'h0011_0000, 32'h0012_0000, 32'h0012_8000, 32'h0014_0000,
    32'h0014_8000, 32'h0015_0000, 32'h0015_8000, 32'h0017_0000, 32'h0017_8000,
    32'h0018_0000, 32'h0040_8000, 32'h0044_8000, 32'h0048_8000,
    32'h0200_0000, 32'h0240_0000, 32'h0280_0000, 32'h0340_0000, 32'h0380_0000,
    32'h03c0_0000, 32'h1400_0000, 32'h1c00_0000,
    32'h2800_0000, 32'h2840_0000, 32'h2880_0000, 32'h2a00_0000, 32'h2a40_0000,
    32'h2900_0000, 32'h2940_0000, 32'h2980_0000,
    32'h4c00_0000, 32'h5000_0000, 32'h5400_0000, 32'h5800_0000, 32'h5c00_0000,
    32'h6000_0000, 32'h6400_0000, 32'h6800_0000, 32'h6c00_0000
  };

  id_stage i_id_stage (
    .clk        (clk),
    .reset      (reset),
    .if_valid   (if_valid),
    .if_bus     (if_bus),
    .id_allowin (id_allowin),
    .exe_allowin(exe_allowin),
    .exe_valid  (exe_valid),
    .exe_bus    (exe_bus),
    .br_bus     (br_bus),
    .exe_bypass (exe_bypass),
    .mem_bypass (mem_bypass),
    .wb_bypass  (wb_bypass)
  );

  always #2 clk = ~clk;

  function automatic logic [31:0] rand32();
    seed = seed * 32'd1103515245 + 32'd12345;
    return seed;
  endfunction

  function automatic int unsigned rand_below(input int unsigned n);
    return (rand32() >> 12) % n;
  endfunction

  function automatic logic [31:0] next_pc();
    pc_tag = pc_tag + 32'd4;
    return pc_tag;
  endfunction

  // random field bits that each instruction format leaves free
  function automatic logic [31:0] mask_of(input logic [31:0] t);
    if (t[31:26] >= 6'h13) return 32'h03ff_ffff;
    if (t[31:28] == 4'h1) return 32'h01ff_ffff;
    if (t[31:23] == '0) return 32'h0000_7fff;
    return 32'h003f_ffff;
  endfunction

  function automatic logic [31:0] rand_inst(input int lo, input int n);
    logic [31:0] t;
    logic [31:0] inst;
    t = ops[lo + rand_below(n)];
    inst = t | (rand32() & mask_of(t));
    // equal operands now and then, so that beq and bge get taken
    if (rand_below(4) == 0) inst[4:0] = inst[9:5];
    return inst;
  endfunction

  function automatic logic [31:0] r3(input logic [31:0] t, input logic [4:0] rd,
                                     input logic [4:0] rj, input logic [4:0] rk);
    return t | {17'h0, rk, rj, rd};
  endfunction

  function automatic bypass_t writer(input logic v, input logic w, input logic ld,
                                     input logic [4:0] a, input logic [31:0] d);
    bypass_t b;
    b.valid     = v;
    b.reg_write = w;
    b.from_mem  = ld;
    b.addr      = a;
    b.data      = d;
    return b;
  endfunction

  function automatic kind_t kind(input fmt_t f, input alu_op_t a, input mem_width_t w,
                                 input logic s);
    kind_t k;
    k.fmt = f;
    k.alu = a;
    k.w   = w;
    k.sgn = s;
    return k;
  endfunction

  // youngest matching writer, else the register file
  function automatic logic [31:0] operand(input logic [4:0] a, input logic need,
                                          input bypass_t e, input bypass_t m, input bypass_t w);
    if (a == '0) return '0;
    if (need && e.valid && e.reg_write && e.addr == a) return e.data;
    if (need && m.valid && m.reg_write && m.addr == a) return m.data;
    if (need && w.valid && w.reg_write && w.addr == a) return w.data;
    return regs[a];
  endfunction

  function automatic void ref_model(input logic [31:0] inst, input logic [31:0] pc,
                                    input bypass_t e, input bypass_t m, input bypass_t w,
                                    output id_to_exe_t x, output br_to_if_t b,
                                    output logic hz);
    kind_t       k;
    logic [4:0]  rkd;
    logic        need_rj;
    logic        need_rkd;
    logic [31:0] a;
    logic [31:0] c;
    logic [31:0] imm;
    logic [31:0] offset;
    logic        cond;
    k = kind(f_none, alu_add, mem_none, 1'b0);
    case (inst[31:15])
      17'h00020: k = kind(f_3r, alu_add, mem_none, 1'b0);
      17'h00022: k = kind(f_3r, alu_sub, mem_none, 1'b0);
      17'h00024: k = kind(f_3r, alu_slt, mem_none, 1'b0);
      17'h00025: k = kind(f_3r, alu_sltu, mem_none, 1'b0);
      17'h00028: k = kind(f_3r, alu_nor, mem_none, 1'b0);
      17'h00029: k = kind(f_3r, alu_and, mem_none, 1'b0);
      17'h0002a: k = kind(f_3r, alu_or, mem_none, 1'b0);
      17'h0002b: k = kind(f_3r, alu_xor, mem_none, 1'b0);
      17'h0002e: k = kind(f_3r, alu_sll, mem_none, 1'b0);
      17'h0002f: k = kind(f_3r, alu_srl, mem_none, 1'b0);
      17'h00030: k = kind(f_3r, alu_sra, mem_none, 1'b0);
      17'h00081: k = kind(f_ui5, alu_sll, mem_none, 1'b0);
      17'h00089: k = kind(f_ui5, alu_srl, mem_none, 1'b0);
      17'h00091: k = kind(f_ui5, alu_sra, mem_none, 1'b0);
      default: ;
    endcase
    case (inst[31:22])
      10'h008: k = kind(f_si12, alu_slt, mem_none, 1'b0);
      10'h009: k = kind(f_si12, alu_sltu, mem_none, 1'b0);
      10'h00a: k = kind(f_si12, alu_add, mem_none, 1'b0);
      10'h00d: k = kind(f_ui12, alu_and, mem_none, 1'b0);
      10'h00e: k = kind(f_ui12, alu_or, mem_none, 1'b0);
      10'h00f: k = kind(f_ui12, alu_xor, mem_none, 1'b0);
      10'h0a0: k = kind(f_ld, alu_add, mem_byte, 1'b1);
      10'h0a1: k = kind(f_ld, alu_add, mem_half, 1'b1);
      10'h0a2: k = kind(f_ld, alu_add, mem_word, 1'b1);
      10'h0a4: k = kind(f_st, alu_add, mem_byte, 1'b0);
      10'h0a5: k = kind(f_st, alu_add, mem_half, 1'b0);
      10'h0a6: k = kind(f_st, alu_add, mem_word, 1'b0);
      10'h0a8: k = kind(f_ld, alu_add, mem_byte, 1'b0);
      10'h0a9: k = kind(f_ld, alu_add, mem_half, 1'b0);
      default: ;
    endcase
    case (inst[31:25])
      7'h0a: k = kind(f_u20, alu_lui, mem_none, 1'b0);
      7'h0e: k = kind(f_pcu, alu_add, mem_none, 1'b0);
      default: ;
    endcase
    case (inst[31:26])
      6'h13: k = kind(f_jirl, alu_add, mem_none, 1'b0);
      6'h14: k = kind(f_b, alu_add, mem_none, 1'b0);
      6'h15: k = kind(f_bl, alu_add, mem_none, 1'b0);
      6'h16, 6'h17, 6'h18, 6'h19, 6'h1a, 6'h1b: k = kind(f_cbr, alu_add, mem_none, 1'b0);
      default: ;
    endcase
    rkd = (k.fmt inside {f_st, f_cbr}) ? inst[4:0] : inst[14:10];
    need_rj = !(k.fmt inside {f_none, f_b, f_bl, f_u20, f_pcu});
    need_rkd = k.fmt inside {f_3r, f_st, f_cbr};
    a = operand(inst[9:5], need_rj, e, m, w);
    c = operand(rkd, need_rkd, e, m, w);
    hz = e.valid && e.from_mem &&
         ((need_rj && inst[9:5] != '0 && e.addr == inst[9:5]) ||
          (need_rkd && rkd != '0 && e.addr == rkd));
    case (k.fmt)
      f_jirl, f_bl: imm = 32'd4;
      f_u20, f_pcu: imm = {inst[24:5], 12'h0};
      f_ui12:       imm = {20'h0, inst[21:10]};
      f_ui5:        imm = {27'h0, inst[14:10]};
      default:      imm = {{20{inst[21]}}, inst[21:10]};
    endcase
    x.alu_op       = k.alu;
    x.res_from_mem = k.fmt == f_ld;
    x.reg_write    = !(k.fmt inside {f_none, f_st, f_cbr, f_b});
    x.mem_write    = k.fmt == f_st;
    x.dest         = (k.fmt == f_bl) ? 5'd1 : inst[4:0];
    x.store_data   = c;
    x.src1         = (k.fmt inside {f_jirl, f_bl, f_pcu}) ? pc : a;
    x.src2         = (k.fmt inside {f_3r, f_cbr, f_b, f_none}) ? c : imm;
    x.mem_width    = k.w;
    x.load_sign    = k.sgn;
    x.pc           = pc;
    case (inst[31:26])
      6'h16:   cond = a == c;
      6'h17:   cond = a != c;
      6'h18:   cond = $signed(a) < $signed(c);
      6'h19:   cond = $signed(a) >= $signed(c);
      6'h1a:   cond = a < c;
      6'h1b:   cond = a >= c;
      6'h13, 6'h14, 6'h15: cond = 1'b1;
      default: cond = 1'b0;
    endcase
    if (k.fmt inside {f_b, f_bl}) offset = {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b0};
    else offset = {{14{inst[25]}}, inst[25:10], 2'b0};
    b.taken  = cond;
    b.stall  = cond && hz;
    b.target = ((k.fmt == f_jirl) ? a : pc) + offset;
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("test failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_exe(input id_to_exe_t got, input id_to_exe_t exp);
    if (got !== exp) abort_run($sformatf("FAILED time %0t: exe_bus got %h expected %h",
                                         $time, got, exp));
  endtask

  task automatic check_br(input br_to_if_t got, input br_to_if_t exp);
    if (got !== exp) abort_run($sformatf("FAILED time %0t: br_bus got %h expected %h",
                                         $time, got, exp));
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) abort_run($sformatf("FAILED time %0t: %s got %b expected %b",
                                         $time, name, got, exp));
  endtask

  // model of the stage register, stepped where all inputs are stable
  always @(negedge clk) begin
    id_to_exe_t exp_exe;
    br_to_if_t  exp_br;
    logic       hz;
    logic       free;
    if (reset) begin
      m_valid = 1'b0;
    end else begin
      ref_model(m_inst, m_pc, exe_bypass, mem_bypass, wb_bypass, exp_exe, exp_br, hz);
      free = !m_valid || (!hz && exe_allowin);
      check_bit("exe_valid", exe_valid, m_valid && !hz);
      check_bit("id_allowin", id_allowin, free);
      // branch result counts while a hazard holds the stage too
      if (m_valid) begin
        check_br(br_bus, exp_br);
      end else begin
        check_bit("br_bus.taken", br_bus.taken, 1'b0);
        check_bit("br_bus.stall", br_bus.stall, 1'b0);
      end
      if (m_valid && !hz) begin
        check_exe(exe_bus, exp_exe);
      end
      if (exe_valid && exe_allowin) begin
        pending = pending - 1;
      end
      if (free) begin
        // fetch's offer is dropped behind a taken branch
        m_valid = if_valid && !(m_valid && !hz && exp_br.taken);
        if (m_valid) begin
          m_inst  = if_bus.inst;
          m_pc    = if_bus.pc;
          pending = pending + 1;
        end
      end
      if (wb_bypass.valid && wb_bypass.reg_write && wb_bypass.addr != '0) begin
        regs[wb_bypass.addr] = wb_bypass.data;
      end
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= max_cycles) abort_run("timeout, the run did not finish in time");
  end

  task automatic offer(input logic [31:0] pc, input logic [31:0] inst, input logic bp);
    logic acc;
    if_valid <= 1'b1;
    if_bus   <= {pc, inst};
    acc = 1'b0;
    while (!acc) begin
      @(negedge clk);
      acc = id_allowin;
      @(posedge clk);
      if (bp) exe_allowin <= rand_below(2) != 0;
    end
  endtask

  task automatic wait_empty();
    while (pending != 0) @(posedge clk);
  endtask

  task automatic send(input logic [31:0] inst);
    offer(next_pc(), inst, 1'b0);
    if_valid <= 1'b0;
    wait_empty();
  endtask

  task automatic stream(input int n, input int lo, input int cnt, input logic bp);
    repeat (n) offer(next_pc(), rand_inst(lo, cnt), bp);
    if_valid    <= 1'b0;
    exe_allowin <= 1'b1;
    wait_empty();
  endtask

  initial begin
    reset       = 1'b1;
    if_valid    = 1'b0;
    if_bus      = '0;
    exe_allowin = 1'b1;
    exe_bypass  = '0;
    mem_bypass  = '0;
    wb_bypass   = '0;
    for (int i = 0; i < 32; i++) regs[i] = '0;
    repeat (2) @(posedge clk);
    reset <= 1'b0;

    // fill the register file, r0 included
    for (int i = 0; i < 32; i++) begin
      wb_bypass <= writer(1'b1, 1'b1, 1'b0, i[4:0], rand32());
      @(posedge clk);
    end
    wb_bypass <= '0;
    send(r3(ops[0], 5'd2, 5'd0, 5'd0));
    stream(100, 0, 22, 1'b0);
    stream(60, 22, 8, 1'b0);

    // forwarding priority on r5
    exe_bypass <= writer(1'b1, 1'b1, 1'b0, 5'd5, 32'haaaa_0001);
    mem_bypass <= writer(1'b1, 1'b1, 1'b0, 5'd5, 32'hbbbb_0002);
    wb_bypass  <= writer(1'b1, 1'b1, 1'b0, 5'd5, 32'hcccc_0003);
    send(r3(ops[0], 5'd3, 5'd5, 5'd5));
    exe_bypass <= writer(1'b0, 1'b1, 1'b0, 5'd5, 32'haaaa_0001);
    send(r3(ops[1], 5'd3, 5'd5, 5'd5));
    exe_bypass <= writer(1'b1, 1'b0, 1'b0, 5'd5, 32'haaaa_0001);
    mem_bypass <= writer(1'b0, 1'b1, 1'b0, 5'd5, 32'hbbbb_0002);
    send(r3(ops[6], 5'd3, 5'd5, 5'd5));
    exe_bypass <= '0;
    mem_bypass <= '0;
    wb_bypass  <= '0;

    // load in exe feeding r7
    exe_bypass <= writer(1'b1, 1'b1, 1'b1, 5'd7, 32'h0bad_f00d);
    offer(next_pc(), r3(ops[0], 5'd3, 5'd7, 5'd2), 1'b0);
    if_valid <= 1'b0;
    repeat (3) @(posedge clk);
    exe_bypass <= '0;
    wait_empty();

    // jirl on a loaded r7 is taken but stalled
    exe_bypass <= writer(1'b1, 1'b1, 1'b1, 5'd7, 32'h0bad_f00d);
    offer(next_pc(), r3(ops[30], 5'd1, 5'd7, 5'd4), 1'b0);
    if_valid <= 1'b0;
    repeat (3) @(posedge clk);
    exe_bypass <= '0;
    wait_empty();

    stream(150, 30, 9, 1'b0);
    stream(800, 0, 39, 1'b1);
    $display("test passed");
    $finish;
  end

endmodule
